// ==== logic/core_pkg.sv ====
////////////////////
// global control register map
// offsets, readback indices, field positions and reset values
////////////////////

package core_pkg;

  // widths with a meaning on the settings bus
  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] set_data_t;
  typedef logic [4:0]  rb_sel_t;
  typedef logic [1:0]  pps_sel_t;
  typedef logic [1:0]  lock_t;
  typedef logic [3:0]  tcxo_t;
  typedef logic [7:0]  xb_addr_t;

  ////////////////////
  // settings-bus write offsets
  localparam set_addr_t SR_READBACK = 8'd0;
  localparam set_addr_t SR_MISC     = 8'd4;
  localparam set_addr_t SR_TEST     = 8'd28;
  localparam set_addr_t SR_XB_LOCAL = 8'd32;

  ////////////////////
  // readback indices
  localparam rb_sel_t RB_MISC   = 5'd1;
  localparam rb_sel_t RB_COMPAT = 5'd2;
  localparam rb_sel_t RB_PLL    = 5'd4;
  localparam rb_sel_t RB_NUMCE  = 5'd8;
  localparam rb_sel_t RB_TEST   = 5'd24;

  // fixed words and reset values
  localparam set_data_t  COMPAT_WORD    = 32'hAC00_FF00;
  localparam logic [3:0] NUM_CE         = 4'd0;
  localparam set_data_t  RB_DEFAULT     = 32'hDEAD_BEEF;
  // internal pps selected out of reset
  localparam set_data_t  MISC_RESET     = 32'd2;
  localparam xb_addr_t   XB_LOCAL_RESET = 8'd40;

  // misc register fields
  localparam int MISC_PPS_LSB        = 0;
  localparam int MISC_MIMO_BIT       = 2;
  localparam int MISC_CODEC_ARST_BIT = 3;
  localparam int MISC_TIME_SYNC_BIT  = 21;

endpackage

// ==== logic/core_wr_if.sv ====
////////////////////
// decoded settings writes, one pulse per register
////////////////////

`timescale 1ns/1ps

interface core_wr_if;

  logic                 wr_misc;
  logic                 wr_test;
  logic                 wr_rb_sel;
  logic                 wr_xb_local;
  // qualified by whichever pulse is high
  core_pkg::set_data_t  data;

  modport src (output wr_misc, output wr_test, output wr_rb_sel,
               output wr_xb_local, output data);

  modport dst (input wr_misc, input wr_test, input wr_rb_sel,
               input wr_xb_local, input data);

endinterface

// ==== logic/core_state_if.sv ====
////////////////////
// register state seen by the readback stage
////////////////////

`timescale 1ns/1ps

interface core_state_if;

  // level values, held until the next write
  core_pkg::rb_sel_t    rb_sel;
  core_pkg::set_data_t  test_val;
  core_pkg::set_data_t  misc_val;
  core_pkg::pps_sel_t   pps_select;

  modport src (
    output rb_sel,
    output test_val,
    output misc_val,
    output pps_select
  );

  modport dst (
    input rb_sel,
    input test_val,
    input misc_val,
    input pps_select
  );

endinterface

// ==== logic/set_decode.sv ====
////////////////////
// settings-bus address decode
// one registered write pulse per global register
////////////////////

`timescale 1ns/1ps

module set_decode (
  input  logic                 bus_clk,
  input  logic                 bus_rst,
  input  logic                 i_set_stb,
  input  core_pkg::set_addr_t  i_set_addr,
  input  core_pkg::set_data_t  i_set_data,
  core_wr_if.src               o_wr
);

  logic hit_rb_sel;
  logic hit_misc;
  logic hit_test;
  logic hit_xb_local;

  // address compare, unknown offsets match nothing
  assign hit_rb_sel   = (i_set_addr == core_pkg::SR_READBACK);
  assign hit_misc     = (i_set_addr == core_pkg::SR_MISC);
  assign hit_test     = (i_set_addr == core_pkg::SR_TEST);
  assign hit_xb_local = (i_set_addr == core_pkg::SR_XB_LOCAL);

  ////////////////////
  // write pulses
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_wr.wr_rb_sel   <= 1'b0;
      o_wr.wr_misc     <= 1'b0;
      o_wr.wr_test     <= 1'b0;
      o_wr.wr_xb_local <= 1'b0;
    end else begin
      o_wr.wr_rb_sel   <= i_set_stb && hit_rb_sel;
      o_wr.wr_misc     <= i_set_stb && hit_misc;
      o_wr.wr_test     <= i_set_stb && hit_test;
      o_wr.wr_xb_local <= i_set_stb && hit_xb_local;
    end
  end

  // data rides alongside the pulse
  always_ff @(posedge bus_clk) begin
    o_wr.data <= i_set_data;
  end

endmodule

// ==== logic/core_regs.sv ====
////////////////////
// global register storage
// readback select, test, misc and crossbar local address
////////////////////

`timescale 1ns/1ps

module core_regs (
  input  logic                 bus_clk,
  input  logic                 bus_rst,
  core_wr_if.dst               i_wr,
  core_state_if.src            o_state,
  output core_pkg::pps_sel_t   o_pps_select,
  output logic                 o_mimo,
  output logic                 o_codec_arst,
  output logic                 o_time_sync,
  output core_pkg::xb_addr_t   o_xb_local_addr
);

  core_pkg::rb_sel_t    rb_sel_reg;
  core_pkg::set_data_t  test_reg;
  core_pkg::set_data_t  misc_reg;
  core_pkg::xb_addr_t   xb_local_reg;

  ////////////////////
  // registers
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rb_sel_reg <= '0;
    end else if (i_wr.wr_rb_sel) begin
      // only the low bits index the readback map
      rb_sel_reg <= i_wr.data[$bits(core_pkg::rb_sel_t)-1:0];
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      test_reg <= '0;
    end else if (i_wr.wr_test) begin
      test_reg <= i_wr.data;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      misc_reg <= core_pkg::MISC_RESET;
    end else if (i_wr.wr_misc) begin
      misc_reg <= i_wr.data;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      xb_local_reg <= core_pkg::XB_LOCAL_RESET;
    end else if (i_wr.wr_xb_local) begin
      xb_local_reg <= i_wr.data[$bits(core_pkg::xb_addr_t)-1:0];
    end
  end

  ////////////////////
  // misc field split
  assign o_pps_select =
    misc_reg[core_pkg::MISC_PPS_LSB +: $bits(core_pkg::pps_sel_t)];
  assign o_mimo          = misc_reg[core_pkg::MISC_MIMO_BIT];
  assign o_codec_arst    = misc_reg[core_pkg::MISC_CODEC_ARST_BIT];
  // time sync stays a plain bus-domain bit here
  assign o_time_sync     = misc_reg[core_pkg::MISC_TIME_SYNC_BIT];
  assign o_xb_local_addr = xb_local_reg;

  // state for the readback stage
  assign o_state.rb_sel     = rb_sel_reg;
  assign o_state.test_val   = test_reg;
  assign o_state.misc_val   = misc_reg;
  assign o_state.pps_select = o_pps_select;

endmodule

// ==== logic/core_readback.sv ====
////////////////////
// registered readback mux
// pll lock pair through a two-flop synchronizer
////////////////////

`timescale 1ns/1ps

module core_readback (
  input  logic                 bus_clk,
  input  logic                 bus_rst,
  core_state_if.dst            i_state,
  input  core_pkg::tcxo_t      i_tcxo_status,
  input  core_pkg::lock_t      i_lock,
  output core_pkg::set_data_t  o_rb_data
);

  core_pkg::lock_t      lock_meta;
  core_pkg::lock_t      lock_sync;
  core_pkg::set_data_t  rb_next;

  ////////////////////
  // lock synchronizer
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_meta <= '0;
      lock_sync <= '0;
    end else begin
      lock_meta <= i_lock;
      lock_sync <= lock_meta;
    end
  end

  ////////////////////
  // word select
  always_comb begin
    case (i_state.rb_sel)
      core_pkg::RB_MISC: begin
        rb_next = {26'd0, i_tcxo_status, i_state.pps_select};
      end
      core_pkg::RB_COMPAT: begin
        rb_next = core_pkg::COMPAT_WORD;
      end
      core_pkg::RB_PLL: begin
        rb_next = {30'd0, lock_sync};
      end
      core_pkg::RB_NUMCE: begin
        rb_next = {28'd0, core_pkg::NUM_CE};
      end
      core_pkg::RB_TEST: begin
        rb_next = i_state.test_val;
      end
      default: begin
        rb_next = core_pkg::RB_DEFAULT;
      end
    endcase
  end

  // output register, index 0 is unmapped after reset
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_rb_data <= core_pkg::RB_DEFAULT;
    end else begin
      o_rb_data <= rb_next;
    end
  end

endmodule

// ==== logic/core_ctrl_top.sv ====
////////////////////
// global control block top level
////////////////////

`timescale 1ns/1ps

module core_ctrl_top (
  input  logic                 bus_clk,
  input  logic                 bus_rst,

  // settings bus from the host
  input  logic                 i_set_stb,
  input  core_pkg::set_addr_t  i_set_addr,
  input  core_pkg::set_data_t  i_set_data,

  // status inputs
  input  core_pkg::tcxo_t      i_tcxo_status,
  input  core_pkg::lock_t      i_lock,

  output core_pkg::set_data_t  o_rb_data,

  // control outputs from the misc register
  output core_pkg::pps_sel_t   o_pps_select,
  output logic                 o_mimo,
  output logic                 o_codec_arst,
  output logic                 o_time_sync,
  output core_pkg::xb_addr_t   o_xb_local_addr
);

  core_wr_if    wr_bus ();
  core_state_if state_bus ();

  ////////////////////
  // stage 1, address decode
  set_decode set_decode_inst (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_wr       (wr_bus.src)
  );

  ////////////////////
  // stage 2, register storage
  core_regs core_regs_inst (
    .bus_clk         (bus_clk),
    .bus_rst         (bus_rst),
    .i_wr            (wr_bus.dst),
    .o_state         (state_bus.src),
    .o_pps_select    (o_pps_select),
    .o_mimo          (o_mimo),
    .o_codec_arst    (o_codec_arst),
    .o_time_sync     (o_time_sync),
    .o_xb_local_addr (o_xb_local_addr)
  );

  ////////////////////
  // stage 3, readback
  core_readback core_readback_inst (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_state       (state_bus.dst),
    .i_tcxo_status (i_tcxo_status),
    .i_lock        (i_lock),
    .o_rb_data     (o_rb_data)
  );

endmodule

// ==== bench/core_ctrl_tb.sv ====
////////////////////
// testbench for the global control block
// settings-bus writes, readback map and lock sync
////////////////////

`timescale 1ns/1ps

module core_ctrl_tb;

  logic                 bus_clk;
  logic                 bus_rst;
  logic                 i_set_stb;
  core_pkg::set_addr_t  i_set_addr;
  core_pkg::set_data_t  i_set_data;
  core_pkg::tcxo_t      i_tcxo_status;
  core_pkg::lock_t      i_lock;
  core_pkg::set_data_t  o_rb_data;
  core_pkg::pps_sel_t   o_pps_select;
  logic                 o_mimo;
  logic                 o_codec_arst;
  logic                 o_time_sync;
  core_pkg::xb_addr_t   o_xb_local_addr;

  // reference model of the written registers
  core_pkg::set_data_t  model_misc;
  core_pkg::set_data_t  model_test;
  core_pkg::xb_addr_t   model_xb;

  string                cur_test;
  int                   test_err;
  int                   pass_count;
  int                   fail_count;
  int                   checks;
  logic [31:0]          rnd;
  core_pkg::set_data_t  word;
  core_pkg::set_data_t  first_word;
  core_pkg::lock_t      lock_val;
  logic                 seen;
  int                   i;
  int                   n;

  // misc write history for the two-cycle check
  logic                 misc_wr_d1 = 1'b0;
  logic                 misc_wr_d2 = 1'b0;
  core_pkg::set_data_t  misc_data_d1 = '0;
  core_pkg::set_data_t  misc_data_d2 = '0;

  core_ctrl_top core_ctrl_top_inst (
    .bus_clk         (bus_clk),
    .bus_rst         (bus_rst),
    .i_set_stb       (i_set_stb),
    .i_set_addr      (i_set_addr),
    .i_set_data      (i_set_data),
    .i_tcxo_status   (i_tcxo_status),
    .i_lock          (i_lock),
    .o_rb_data       (o_rb_data),
    .o_pps_select    (o_pps_select),
    .o_mimo          (o_mimo),
    .o_codec_arst    (o_codec_arst),
    .o_time_sync     (o_time_sync),
    .o_xb_local_addr (o_xb_local_addr)
  );

  always #5 bus_clk = ~bus_clk;

  ////////////////////
  // helpers
  function automatic logic [4:0] misc_fields(input core_pkg::set_data_t w);
    return {w[core_pkg::MISC_PPS_LSB +: 2], w[core_pkg::MISC_MIMO_BIT],
            w[core_pkg::MISC_CODEC_ARST_BIT], w[core_pkg::MISC_TIME_SYNC_BIT]};
  endfunction

  task automatic check_word(input string what, input core_pkg::set_data_t exp,
                            input core_pkg::set_data_t act);
    checks++;
    assert (act === exp) else begin
      $display("ERROR %s %s expected %h actual %h", cur_test, what, exp, act);
      test_err++;
    end
  endtask

  task automatic wait_rise(input int count);
    for (int k = 0; k < count; k++) begin
      @(posedge bus_clk);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err = 0;
  endtask

  task automatic end_test();
    if (test_err == 0) begin
      pass_count++;
      $display("PASS %s", cur_test);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d errors", cur_test, test_err);
    end
  endtask

  // one-cycle strobe, called and returning on a falling edge
  task automatic set_write(input core_pkg::set_addr_t addr, input core_pkg::set_data_t data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    if (addr == core_pkg::SR_MISC) model_misc = data;
    if (addr == core_pkg::SR_TEST) model_test = data;
    if (addr == core_pkg::SR_XB_LOCAL) model_xb = data[7:0];
    @(negedge bus_clk);
    i_set_stb = 1'b0;
  endtask

  // select, then three rising edges from the strobe
  task automatic read_word(input core_pkg::rb_sel_t idx, output core_pkg::set_data_t data);
    set_write(core_pkg::SR_READBACK, {27'd0, idx});
    wait_rise(2);
    @(negedge bus_clk);
    data = o_rb_data;
  endtask

  ////////////////////
  // misc fields two cycles after each strobe
  always @(posedge bus_clk) begin
    misc_wr_d1   <= i_set_stb && (i_set_addr == core_pkg::SR_MISC) && !bus_rst;
    misc_data_d1 <= i_set_data;
    misc_wr_d2   <= misc_wr_d1;
    misc_data_d2 <= misc_data_d1;
  end

  always @(negedge bus_clk) begin
    if (misc_wr_d2) begin
      check_word("misc fields", {27'd0, misc_fields(misc_data_d2)},
                 {27'd0, o_pps_select, o_mimo, o_codec_arst, o_time_sync});
    end
  end

  ////////////////////
  // test sequence
  initial begin
    bus_clk = 1'b0;
    bus_rst = 1'b1;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_tcxo_status = '0;
    i_lock = '0;
    model_misc = core_pkg::MISC_RESET;
    model_test = '0;
    model_xb = core_pkg::XB_LOCAL_RESET;
    pass_count = 0;
    fail_count = 0;
    checks = 0;
    rnd = $urandom(32'h9ec8);
    wait_rise(2);
    @(negedge bus_clk);
    bus_rst = 1'b0;

    begin_test("reset_state");
    check_word("control outputs", {27'd0, 5'b10000},
               {27'd0, o_pps_select, o_mimo, o_codec_arst, o_time_sync});
    check_word("xb local addr", 32'd40, {24'd0, o_xb_local_addr});
    check_word("readback", 32'hDEAD_BEEF, o_rb_data);
    end_test();

    begin_test("misc_fields");
    for (i = 0; i < 8; i++) begin
      rnd = $urandom;
      set_write(core_pkg::SR_MISC, rnd);
    end
    wait_rise(3);
    @(negedge bus_clk);
    end_test();

    begin_test("test_register");
    for (i = 0; i < 4; i++) begin
      rnd = $urandom;
      set_write(core_pkg::SR_TEST, rnd);
      read_word(core_pkg::RB_TEST, word);
      check_word("test readback", model_test, word);
    end
    // back to back, test then crossbar address
    rnd = $urandom;
    first_word = rnd;
    set_write(core_pkg::SR_TEST, first_word);
    rnd = $urandom;
    set_write(core_pkg::SR_XB_LOCAL, rnd);
    read_word(core_pkg::RB_TEST, word);
    check_word("back to back test", first_word, word);
    check_word("xb local addr", {24'd0, rnd[7:0]}, {24'd0, o_xb_local_addr});
    end_test();

    begin_test("readback_map");
    read_word(core_pkg::RB_COMPAT, word);
    check_word("compat", 32'hAC00_FF00, word);
    read_word(core_pkg::RB_NUMCE, word);
    check_word("numce", 32'd0, word);
    rnd = $urandom;
    i_tcxo_status = rnd[3:0];
    read_word(core_pkg::RB_MISC, word);
    check_word("misc status", {26'd0, rnd[3:0], model_misc[1:0]}, word);
    read_word(5'd0, word);
    check_word("index 0", 32'hDEAD_BEEF, word);
    read_word(5'd3, word);
    check_word("index 3", 32'hDEAD_BEEF, word);
    read_word(5'd31, word);
    check_word("index 31", 32'hDEAD_BEEF, word);
    end_test();

    begin_test("pll_lock_sync");
    read_word(core_pkg::RB_PLL, word);
    for (i = 0; i < 8; i++) begin
      rnd = $urandom;
      lock_val = rnd[1:0];
      i_lock = lock_val;
      seen = 1'b0;
      for (n = 0; n < 3 && !seen; n++) begin
        @(posedge bus_clk);
        @(negedge bus_clk);
        check_word("pll upper bits", 32'd0, {2'b00, o_rb_data[31:2]});
        if (o_rb_data[1:0] === lock_val) seen = 1'b1;
      end
      if (!seen) begin
        $display("%s timed out, lock value %b never reached the readback", cur_test, lock_val);
        test_err++;
      end
    end
    end_test();

    begin_test("unmapped_writes");
    read_word(core_pkg::RB_TEST, word);
    rnd = $urandom;
    set_write(8'd8, rnd);
    set_write(8'd12, ~rnd);
    set_write(8'd60, rnd ^ 32'h5A5A_A5A5);
    wait_rise(3);
    @(negedge bus_clk);
    check_word("control outputs", {27'd0, misc_fields(model_misc)},
               {27'd0, o_pps_select, o_mimo, o_codec_arst, o_time_sync});
    check_word("xb local addr", {24'd0, model_xb}, {24'd0, o_xb_local_addr});
    check_word("test readback", model_test, o_rb_data);
    end_test();

    $display("tests passed %0d failed %0d, checks run %0d", pass_count, fail_count, checks);
    if (fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
logic/core_pkg.sv
logic/core_wr_if.sv
logic/core_state_if.sv
logic/set_decode.sv
logic/core_regs.sv
logic/core_readback.sv
logic/core_ctrl_top.sv
bench/core_ctrl_tb.sv
